// File: design/ipod_pkg.sv
package ipod_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int FLASH_AW   = 23;
  localparam int FLASH_DW   = 32;
  localparam int SAMPLE_W   = 16;
  localparam int PERIOD_W   = 16;
  localparam int HEX_DIGITS = 6;

  // Board defaults, 22 kHz playback over the whole flash
  localparam logic [FLASH_AW-1:0] DEF_ADDR_LAST = '1;
  localparam int unsigned DEF_PERIOD        = 2272;
  localparam int unsigned DEF_SPEED_STEP    = 64;
  localparam int unsigned DEF_MIN_PERIOD    = 1136;
  localparam int unsigned DEF_MAX_PERIOD    = 6250;
  // About ten repeats per second
  localparam int unsigned DEF_REPEAT_CYCLES = 5_000_000;

  // ==============================
  // Grouped signals
  // ==============================
  typedef struct packed {
    logic                read;
    logic [FLASH_AW-1:0] address;
  } flash_req_t;

  typedef struct packed {
    logic                waitrequest;
    logic                readdatavalid;
    logic [FLASH_DW-1:0] readdata;
  } flash_rsp_t;

  typedef struct packed {
    logic                valid;
    logic [SAMPLE_W-1:0] data;
  } audio_sample_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] ascii;
  } kbd_cmd_t;

  // Keys are active low
  typedef struct packed {
    logic faster;
    logic slower;
    logic speed_reset;
  } speed_keys_t;

  typedef struct packed {
    logic playing;
    logic backward;
  } play_state_t;

  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_PLAY,
    CMD_PAUSE,
    CMD_FWD,
    CMD_BWD,
    CMD_RESTART
  } play_cmd_e;

  // Active low, bit 0 is segment a
  typedef logic [6:0] seg7_t;

  // ==============================
  // ASCII command codes
  // ==============================
  localparam logic [7:0] ASCII_E_UP = 8'h45;
  localparam logic [7:0] ASCII_E_LO = 8'h65;
  localparam logic [7:0] ASCII_D_UP = 8'h44;
  localparam logic [7:0] ASCII_D_LO = 8'h64;
  localparam logic [7:0] ASCII_F_UP = 8'h46;
  localparam logic [7:0] ASCII_F_LO = 8'h66;
  localparam logic [7:0] ASCII_B_UP = 8'h42;
  localparam logic [7:0] ASCII_B_LO = 8'h62;
  localparam logic [7:0] ASCII_R_UP = 8'h52;
  localparam logic [7:0] ASCII_R_LO = 8'h72;

endpackage

// File: design/sample_tick_gen.sv
`timescale 1ns/1ps

module sample_tick_gen #(
  parameter int PERIOD_W = ipod_pkg::PERIOD_W
) (
  input  logic                CLK_50M,
  input  logic                arst_n,
  input  logic [PERIOD_W-1:0] period,
  output logic                tick
);

  // Cycles left until the next tick
  logic [PERIOD_W-1:0] cnt;

  // Reload on zero, so one tick per period cycles
  // Period is sampled only at the reload
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cnt  <= '0;
      tick <= 1'b0;
    end
    else if (cnt == '0)
    begin
      cnt  <= period - 1'b1;
      tick <= 1'b1;
    end
    else
    begin
      cnt  <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

  // Strobe never stretches over two cycles
  a_tick_single: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    tick |=> !tick);

endmodule

// File: design/speed_control.sv
`timescale 1ns/1ps

module speed_control #(
  parameter int unsigned DEFAULT_PERIOD = ipod_pkg::DEF_PERIOD,
  parameter int unsigned SPEED_STEP     = ipod_pkg::DEF_SPEED_STEP,
  parameter int unsigned MIN_PERIOD     = ipod_pkg::DEF_MIN_PERIOD,
  parameter int unsigned MAX_PERIOD     = ipod_pkg::DEF_MAX_PERIOD,
  parameter int unsigned REPEAT_CYCLES  = ipod_pkg::DEF_REPEAT_CYCLES
) (
  input  logic                          CLK_50M,
  input  logic                          arst_n,
  input  ipod_pkg::speed_keys_t         keys,
  output logic [ipod_pkg::PERIOD_W-1:0] period
);
  import ipod_pkg::*;

  localparam int RPT_W = $clog2(REPEAT_CYCLES + 1);
  localparam int PW1   = PERIOD_W + 1;

  logic [2:0]          key_meta;
  logic [2:0]          key_sync;
  logic                faster_on;
  logic                slower_on;
  logic                reset_on;
  logic                any_on;
  logic [RPT_W-1:0]    rpt_cnt;
  logic                step_now;
  logic [PW1-1:0]      period_up;
  logic [PERIOD_W-1:0] period_next;

  // ==============================
  // Key synchronizers
  // ==============================
  // Idle level is high
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_meta <= 3'b111;
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= {keys.speed_reset, keys.slower, keys.faster};
      key_sync <= key_meta;
    end
  end

  assign faster_on = ~key_sync[0];
  assign slower_on = ~key_sync[1];
  assign reset_on  = ~key_sync[2];
  assign any_on    = faster_on | slower_on | reset_on;

  // ==============================
  // Repeat limiter
  // ==============================
  // Act on the first held cycle, then once per REPEAT_CYCLES
  assign step_now = any_on && (rpt_cnt == '0);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      rpt_cnt <= '0;
    else if (!any_on)
      rpt_cnt <= '0;
    else if (rpt_cnt == '0)
      rpt_cnt <= RPT_W'(REPEAT_CYCLES - 1);
    else
      rpt_cnt <= rpt_cnt - 1'b1;
  end

  // ==============================
  // Clamped period
  // ==============================
  // One spare bit catches overflow going slower
  assign period_up = {1'b0, period} + PW1'(SPEED_STEP);

  // Speed reset wins, then faster, then slower
  always_comb
  begin
    period_next = period;
    if (reset_on)
      period_next = PERIOD_W'(DEFAULT_PERIOD);
    else if (faster_on)
      period_next = (period < PERIOD_W'(MIN_PERIOD + SPEED_STEP)) ?
                    PERIOD_W'(MIN_PERIOD) : period - PERIOD_W'(SPEED_STEP);
    else if (slower_on)
      period_next = (period_up > PW1'(MAX_PERIOD)) ?
                    PERIOD_W'(MAX_PERIOD) : period_up[PERIOD_W-1:0];
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      period <= PERIOD_W'(DEFAULT_PERIOD);
    else if (step_now)
      period <= period_next;
  end

  // Period never leaves its limits
  a_period_range: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (period >= PERIOD_W'(MIN_PERIOD)) && (period <= PERIOD_W'(MAX_PERIOD)));

endmodule

// File: design/playback_ctrl.sv
`timescale 1ns/1ps

module playback_ctrl (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  ipod_pkg::kbd_cmd_t    kbd_cmd,
  output ipod_pkg::play_state_t play_state,
  output logic                  restart
);
  import ipod_pkg::*;

  play_cmd_e cmd;

  // Letter in either case to command, other codes ignored
  always_comb
  begin
    cmd = CMD_NONE;
    if (kbd_cmd.valid)
    begin
      case (kbd_cmd.ascii)
        ASCII_E_UP, ASCII_E_LO: cmd = CMD_PLAY;
        ASCII_D_UP, ASCII_D_LO: cmd = CMD_PAUSE;
        ASCII_F_UP, ASCII_F_LO: cmd = CMD_FWD;
        ASCII_B_UP, ASCII_B_LO: cmd = CMD_BWD;
        ASCII_R_UP, ASCII_R_LO: cmd = CMD_RESTART;
        default:                cmd = CMD_NONE;
      endcase
    end
  end

  // State and restart strobe one cycle after the command
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      play_state <= '0;
      restart    <= 1'b0;
    end
    else
    begin
      restart <= (cmd == CMD_RESTART);
      case (cmd)
        CMD_PLAY:  play_state.playing  <= 1'b1;
        CMD_PAUSE: play_state.playing  <= 1'b0;
        CMD_FWD:   play_state.backward <= 1'b0;
        CMD_BWD:   play_state.backward <= 1'b1;
        default:   play_state          <= play_state;
      endcase
    end
  end

endmodule

// File: design/flash_sample_reader.sv
`timescale 1ns/1ps

module flash_sample_reader #(
  parameter logic [ipod_pkg::FLASH_AW-1:0] ADDR_LAST = ipod_pkg::DEF_ADDR_LAST
) (
  input  logic                    CLK_50M,
  input  logic                    arst_n,
  input  logic                    tick,
  input  ipod_pkg::play_state_t   play_state,
  input  logic                    restart,
  input  ipod_pkg::flash_rsp_t    flash_rsp,
  output ipod_pkg::flash_req_t    flash_req,
  output ipod_pkg::audio_sample_t audio_sample
);
  import ipod_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_WAIT_DATA
  } rd_state_e;

  rd_state_e           state;
  // Next sample position where half high selects the upper sample
  logic [FLASH_AW-1:0] addr;
  logic                half;
  logic                restart_pend;
  logic                read_q;
  logic                valid_q;
  logic [SAMPLE_W-1:0] data_q;
  logic [FLASH_AW-1:0] next_addr;
  logic                next_half;

  // ==============================
  // Next position
  // ==============================
  // Restart goes to the first sample of the direction
  // Otherwise the half flips and the address moves after the second half
  always_comb
  begin
    next_addr = addr;
    next_half = ~half;
    if (restart_pend || restart)
    begin
      next_addr = play_state.backward ? ADDR_LAST : '0;
      next_half = play_state.backward;
    end
    else if (!play_state.backward && half)
      next_addr = (addr == ADDR_LAST) ? '0 : addr + 1'b1;
    else if (play_state.backward && !half)
      next_addr = (addr == '0) ? ADDR_LAST : addr - 1'b1;
  end

  // ==============================
  // Read FSM
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= ST_IDLE;
      addr         <= '0;
      half         <= 1'b0;
      restart_pend <= 1'b0;
      read_q       <= 1'b0;
      valid_q      <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          // Restart applies at once with no fetch in flight
          if (restart)
          begin
            addr <= next_addr;
            half <= next_half;
          end
          // Paused ticks fall through
          if (tick && play_state.playing)
          begin
            read_q <= 1'b1;
            state  <= ST_REQUEST;
          end
        end
        ST_REQUEST:
        begin
          if (restart)
            restart_pend <= 1'b1;
          // Accepted once waitrequest is low
          if (!flash_rsp.waitrequest)
          begin
            read_q <= 1'b0;
            state  <= ST_WAIT_DATA;
          end
        end
        ST_WAIT_DATA:
        begin
          if (restart)
            restart_pend <= 1'b1;
          if (flash_rsp.readdatavalid)
          begin
            valid_q      <= 1'b1;
            addr         <= next_addr;
            half         <= next_half;
            restart_pend <= 1'b0;
            state        <= ST_IDLE;
          end
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Pick the half for the sample
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      data_q <= '0;
    else if (state == ST_WAIT_DATA && flash_rsp.readdatavalid)
      data_q <= half ? flash_rsp.readdata[2*SAMPLE_W-1:SAMPLE_W]
                     : flash_rsp.readdata[SAMPLE_W-1:0];
  end

  assign flash_req    = '{read: read_q, address: addr};
  assign audio_sample = '{valid: valid_q, data: data_q};

  // Request holds with the same address until accepted
  a_read_held: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_req.read && flash_rsp.waitrequest |=>
      flash_req.read && $stable(flash_req.address));

  // A paused idle reader stays idle and raises no sample
  a_quiet_paused: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (state == ST_IDLE) && !play_state.playing |=> (state == ST_IDLE));

endmodule

// File: design/hex_display.sv
`timescale 1ns/1ps

module hex_display (
  input  logic                          CLK_50M,
  input  logic                          arst_n,
  input  logic [ipod_pkg::PERIOD_W-1:0] period,
  output ipod_pkg::seg7_t               segs [ipod_pkg::HEX_DIGITS]
);
  import ipod_pkg::*;

  // One nibble per digit
  logic [4*HEX_DIGITS-1:0] value_q;

  // Active-low pattern, segment a at bit 0
  function automatic seg7_t hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  // Zero-extended copy, one cycle behind period
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      value_q <= '0;
    else
      value_q <= (4*HEX_DIGITS)'(period);
  end

  always_comb
  begin
    for (int i = 0; i < HEX_DIGITS; i++)
      segs[i] = hex_to_seg(value_q[4*i +: 4]);
  end

endmodule

// File: design/ipod_top.sv
`timescale 1ns/1ps

module ipod_top #(
  parameter logic [ipod_pkg::FLASH_AW-1:0] ADDR_LAST = ipod_pkg::DEF_ADDR_LAST,
  parameter int unsigned DEFAULT_PERIOD = ipod_pkg::DEF_PERIOD,
  parameter int unsigned SPEED_STEP     = ipod_pkg::DEF_SPEED_STEP,
  parameter int unsigned MIN_PERIOD     = ipod_pkg::DEF_MIN_PERIOD,
  parameter int unsigned MAX_PERIOD     = ipod_pkg::DEF_MAX_PERIOD,
  parameter int unsigned REPEAT_CYCLES  = ipod_pkg::DEF_REPEAT_CYCLES
) (
  input  logic                    CLK_50M,
  input  logic                    arst_n,
  input  ipod_pkg::kbd_cmd_t      kbd_cmd,
  input  ipod_pkg::speed_keys_t   speed_keys,
  input  ipod_pkg::flash_rsp_t    flash_rsp,
  output ipod_pkg::flash_req_t    flash_req,
  output ipod_pkg::audio_sample_t audio_sample,
  output ipod_pkg::seg7_t         hex_segs [ipod_pkg::HEX_DIGITS]
);
  import ipod_pkg::*;

  logic [PERIOD_W-1:0] period;
  logic                tick;
  play_state_t         play_state;
  logic                restart;

  // ==============================
  // Speed path
  // ==============================
  speed_control #(
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .SPEED_STEP     (SPEED_STEP),
    .MIN_PERIOD     (MIN_PERIOD),
    .MAX_PERIOD     (MAX_PERIOD),
    .REPEAT_CYCLES  (REPEAT_CYCLES)
  ) speed0 (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .keys    (speed_keys),
    .period  (period)
  );

  sample_tick_gen #(
    .PERIOD_W (PERIOD_W)
  ) tick_gen0 (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .period  (period),
    .tick    (tick)
  );

  hex_display display0 (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .period  (period),
    .segs    (hex_segs)
  );

  // ==============================
  // Playback path
  // ==============================
  playback_ctrl ctrl0 (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .kbd_cmd    (kbd_cmd),
    .play_state (play_state),
    .restart    (restart)
  );

  flash_sample_reader #(
    .ADDR_LAST (ADDR_LAST)
  ) reader0 (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .tick         (tick),
    .play_state   (play_state),
    .restart      (restart),
    .flash_rsp    (flash_rsp),
    .flash_req    (flash_req),
    .audio_sample (audio_sample)
  );

endmodule

// File: verif/tb_flash_model.sv
`timescale 1ns/1ps

module tb_flash_model (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  ipod_pkg::flash_req_t flash_req,
  output ipod_pkg::flash_rsp_t flash_rsp
);
  import ipod_pkg::*;

  // Wait cycles left before the next read is taken
  logic [2:0]          wait_left;
  // Cycles left before the data returns
  logic [2:0]          lat_left;
  logic                busy;
  logic [FLASH_AW-1:0] addr_q;
  logic                rdv_q;
  logic [FLASH_DW-1:0] data_q;

  // High half is address plus 0x1000, low half address plus 0x2000
  function automatic logic [FLASH_DW-1:0] word_at(input logic [FLASH_AW-1:0] a);
    logic [15:0] a16;
    a16 = a[15:0];
    return {a16 + 16'h1000, a16 + 16'h2000};
  endfunction

  assign flash_rsp = '{waitrequest: (wait_left != 3'd0), readdatavalid: rdv_q,
                       readdata: data_q};

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wait_left <= 3'd0;
      lat_left  <= 3'd0;
      busy      <= 1'b0;
      addr_q    <= '0;
      rdv_q     <= 1'b0;
      data_q    <= '0;
    end
    else
    begin
      rdv_q <= 1'b0;
      if (flash_req.read && !busy)
      begin
        if (wait_left != 3'd0)
          wait_left <= wait_left - 1'b1;
        else
        begin
          // Taken this cycle, draw the latency and the next wait
          busy      <= 1'b1;
          addr_q    <= flash_req.address;
          lat_left  <= 3'($urandom % 5);
          wait_left <= 3'($urandom % 5);
        end
      end
      else if (busy)
      begin
        if (lat_left == 3'd0)
        begin
          rdv_q  <= 1'b1;
          data_q <= word_at(addr_q);
          busy   <= 1'b0;
        end
        else
          lat_left <= lat_left - 1'b1;
      end
    end
  end

endmodule

// File: verif/tb_ipod_top.sv
`timescale 1ns/1ps

module tb_ipod_top;
  import ipod_pkg::*;

  localparam logic [FLASH_AW-1:0] ADDR_LAST = 23'd7;
  localparam int unsigned DEFAULT_PERIOD = 40;
  localparam int unsigned SPEED_STEP     = 4;
  localparam int unsigned MIN_PERIOD     = 24;
  localparam int unsigned MAX_PERIOD     = 60;
  localparam int unsigned REPEAT_CYCLES  = 16;

  localparam int RESET_CYCLES = 10;
  // Worst case gap between two samples
  localparam int SAMPLE_CYCLES = 2 * MAX_PERIOD;
  localparam int PAUSE_CYCLES  = 300;

  // ==============================
  // Test lengths in cycles
  // ==============================
  localparam int FWD_CYCLES      = 20 * SAMPLE_CYCLES;
  localparam int PAUSE_T_CYCLES  = 8 * SAMPLE_CYCLES + PAUSE_CYCLES;
  localparam int BWD_CYCLES      = 24 * SAMPLE_CYCLES;
  localparam int RESTART_CYCLES  = 12 * SAMPLE_CYCLES;
  localparam int SPEED_CYCLES    = 600;
  localparam int PROTO_CYCLES    = 12 * SAMPLE_CYCLES;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + FWD_CYCLES + PAUSE_T_CYCLES + BWD_CYCLES +
                                   RESTART_CYCLES + SPEED_CYCLES + PROTO_CYCLES + 1000;

  localparam speed_keys_t KEYS_IDLE   = '{faster: 1'b1, slower: 1'b1, speed_reset: 1'b1};
  localparam speed_keys_t KEYS_FASTER = '{faster: 1'b0, slower: 1'b1, speed_reset: 1'b1};
  localparam speed_keys_t KEYS_SLOWER = '{faster: 1'b1, slower: 1'b0, speed_reset: 1'b1};
  localparam speed_keys_t KEYS_RESET  = '{faster: 1'b1, slower: 1'b1, speed_reset: 1'b0};

  // Standard active-low digits, segment a at bit 0
  localparam seg7_t SEG_HEX [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                     7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

  logic          CLK_50M;
  logic          arst_n;
  kbd_cmd_t      kbd_cmd;
  speed_keys_t   speed_keys;
  flash_req_t    flash_req;
  flash_rsp_t    flash_rsp;
  audio_sample_t audio_sample;
  seg7_t         hex_segs [HEX_DIGITS];

  // Expected position and play state
  logic [FLASH_AW-1:0] exp_addr;
  logic                exp_half;
  logic                exp_backward;
  logic                exp_playing;
  logic                display_live;
  logic [SAMPLE_W-1:0] last_data;
  logic                accept;
  int                  paused_for;
  int                  n_samples;
  int                  n_accepts;
  int                  outstanding;
  int                  shown;
  int                  fails        = 0;
  int                  tests_run    = 0;
  int                  tests_failed = 0;

  ipod_top #(
    .ADDR_LAST      (ADDR_LAST),
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .SPEED_STEP     (SPEED_STEP),
    .MIN_PERIOD     (MIN_PERIOD),
    .MAX_PERIOD     (MAX_PERIOD),
    .REPEAT_CYCLES  (REPEAT_CYCLES)
  ) dut0 (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .kbd_cmd      (kbd_cmd),
    .speed_keys   (speed_keys),
    .flash_rsp    (flash_rsp),
    .flash_req    (flash_req),
    .audio_sample (audio_sample),
    .hex_segs     (hex_segs)
  );

  tb_flash_model flash0 (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  task automatic report_mismatch(input string msg);
    fails = fails + 1;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic report_problem(input string msg);
    fails = fails + 1;
    $display("Problem at %0t ns: %s", $time, msg);
  endtask

  function automatic logic [SAMPLE_W-1:0] expected_sample(input logic [FLASH_AW-1:0] a,
                                                          input logic h);
    logic [15:0] a16;
    a16 = a[15:0];
    return h ? a16 + 16'h1000 : a16 + 16'h2000;
  endfunction

  function automatic int digit_value(input seg7_t s);
    for (int n = 0; n < 16; n++)
      if (SEG_HEX[n] == s)
        return n;
    return -1;
  endfunction

  // Period read back from the display, -1 on a bad digit
  always_comb
  begin
    int d;
    shown = 0;
    for (int i = HEX_DIGITS - 1; i >= 0; i--)
    begin
      d = digit_value(hex_segs[i]);
      if (shown >= 0 && d >= 0)
        shown = shown * 16 + d;
      else
        shown = -1;
    end
  end

  assign accept = flash_req.read && !flash_rsp.waitrequest;

  // ==============================
  // Expected position model
  // ==============================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      exp_addr     <= '0;
      exp_half     <= 1'b0;
      exp_backward <= 1'b0;
      exp_playing  <= 1'b0;
      display_live <= 1'b0;
      last_data    <= '0;
      paused_for   <= 0;
      n_samples    <= 0;
      n_accepts    <= 0;
      outstanding  <= 0;
    end
    else
    begin
      display_live <= 1'b1;
      paused_for   <= exp_playing ? 0 : paused_for + 1;
      outstanding  <= outstanding + (accept ? 1 : 0) - (audio_sample.valid ? 1 : 0);
      if (accept)
        n_accepts <= n_accepts + 1;
      if (audio_sample.valid)
      begin
        n_samples <= n_samples + 1;
        last_data <= audio_sample.data;
        // Half always flips, address moves after the second half of a word
        exp_half  <= ~exp_half;
        if (!exp_backward && exp_half)
          exp_addr <= (exp_addr == ADDR_LAST) ? '0 : exp_addr + 1'b1;
        else if (exp_backward && !exp_half)
          exp_addr <= (exp_addr == '0) ? ADDR_LAST : exp_addr - 1'b1;
      end
      if (kbd_cmd.valid)
      begin
        case (kbd_cmd.ascii)
          ASCII_E_UP, ASCII_E_LO: exp_playing  <= 1'b1;
          ASCII_D_UP, ASCII_D_LO: exp_playing  <= 1'b0;
          ASCII_F_UP, ASCII_F_LO: exp_backward <= 1'b0;
          ASCII_B_UP, ASCII_B_LO: exp_backward <= 1'b1;
          ASCII_R_UP, ASCII_R_LO:
          begin
            // First sample of the current direction
            exp_addr <= exp_backward ? ADDR_LAST : '0;
            exp_half <= exp_backward;
          end
          default: ;
        endcase
      end
    end
  end

  // ==============================
  // Checking assertions
  // ==============================
  a_sample_order: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    audio_sample.valid |-> audio_sample.data == expected_sample(exp_addr, exp_half))
    else report_mismatch($sformatf("sample %h, expected %h", $sampled(audio_sample.data),
                                   expected_sample($sampled(exp_addr), $sampled(exp_half))));

  // Margin covers a fetch that was already in flight
  a_quiet_pause: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    paused_for >= 16 |-> !audio_sample.valid)
    else report_mismatch("audio sample while paused");

  a_single_read: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    accept |-> outstanding == 0)
    else report_mismatch("flash read taken while another is outstanding");

  a_sample_per_read: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    audio_sample.valid |-> outstanding == 1)
    else report_mismatch("audio sample without an accepted flash read");

  a_read_kept: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read)
    else report_mismatch("flash read dropped before acceptance");

  a_display: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    display_live |-> (shown >= int'(MIN_PERIOD)) && (shown <= int'(MAX_PERIOD)))
    else report_mismatch($sformatf("display shows %0d, outside the period range",
                                   $sampled(shown)));

  // ==============================
  // Stimulus helpers
  // ==============================
  // Either letter case, picked at random
  task automatic send_key(input logic [7:0] upper, input logic [7:0] lower);
    logic [7:0] code;
    code = (($urandom % 2) == 0) ? upper : lower;
    @(posedge CLK_50M);
    kbd_cmd <= '{valid: 1'b1, ascii: code};
    @(posedge CLK_50M);
    kbd_cmd <= '{valid: 1'b0, ascii: 8'h00};
  endtask

  task automatic wait_samples(input int count);
    int target;
    int waited;
    target = n_samples + count;
    waited = 0;
    while (n_samples < target && waited < count * SAMPLE_CYCLES)
    begin
      @(posedge CLK_50M);
      waited++;
    end
    if (n_samples < target)
      report_problem($sformatf("only %0d of %0d audio samples arrived in time",
                               count - (target - n_samples), count));
  endtask

  task automatic press_keys(input speed_keys_t keys, input int cycles);
    @(posedge CLK_50M);
    speed_keys <= keys;
    repeat (cycles) @(posedge CLK_50M);
    speed_keys <= KEYS_IDLE;
    // Synchronizer, register and display delay
    repeat (8) @(posedge CLK_50M);
  endtask

  task automatic check_display(input int expected);
    assert (shown == expected)
    else report_mismatch($sformatf("display shows %0d, expected %0d", shown, expected));
  endtask

  task automatic check_last(input logic [SAMPLE_W-1:0] expected);
    assert (last_data == expected)
    else report_mismatch($sformatf("sample after restart %h, expected %h", last_data, expected));
  endtask

  task automatic finish_test(input string name, input int fails_before);
    tests_run++;
    if (fails == fails_before)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d failed checks", name, fails - fails_before);
    end
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial
  begin
    int mark;
    int samples_before;
    void'($urandom(50039));
    kbd_cmd    = '0;
    speed_keys = KEYS_IDLE;
    arst_n     = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK_50M);
    arst_n <= 1'b1;
    repeat (4) @(posedge CLK_50M);

    mark = fails;
    send_key(ASCII_E_UP, ASCII_E_LO);
    wait_samples(20);
    finish_test("forward_playback", mark);

    mark = fails;
    send_key(ASCII_D_UP, ASCII_D_LO);
    samples_before = n_samples;
    repeat (PAUSE_CYCLES) @(posedge CLK_50M);
    assert (n_samples == samples_before)
    else report_mismatch($sformatf("%0d samples while paused", n_samples - samples_before));
    send_key(ASCII_E_UP, ASCII_E_LO);
    wait_samples(4);
    finish_test("pause_resume", mark);

    mark = fails;
    send_key(ASCII_B_UP, ASCII_B_LO);
    wait_samples(20);
    send_key(ASCII_F_UP, ASCII_F_LO);
    wait_samples(4);
    finish_test("backward_playback", mark);

    // Restart in both directions
    mark = fails;
    send_key(ASCII_R_UP, ASCII_R_LO);
    wait_samples(1);
    check_last(expected_sample('0, 1'b0));
    wait_samples(2);
    send_key(ASCII_B_UP, ASCII_B_LO);
    wait_samples(2);
    send_key(ASCII_R_UP, ASCII_R_LO);
    wait_samples(1);
    check_last(expected_sample(ADDR_LAST, 1'b1));
    wait_samples(2);
    send_key(ASCII_F_UP, ASCII_F_LO);
    wait_samples(2);
    finish_test("restart", mark);

    // Short presses step once, long holds run into the limits
    mark = fails;
    check_display(int'(DEFAULT_PERIOD));
    press_keys(KEYS_FASTER, 4);
    check_display(int'(DEFAULT_PERIOD - SPEED_STEP));
    press_keys(KEYS_FASTER, 6 * REPEAT_CYCLES);
    check_display(int'(MIN_PERIOD));
    press_keys(KEYS_SLOWER, 4);
    check_display(int'(MIN_PERIOD + SPEED_STEP));
    press_keys(KEYS_SLOWER, 12 * REPEAT_CYCLES);
    check_display(int'(MAX_PERIOD));
    press_keys(KEYS_RESET, 4);
    check_display(int'(DEFAULT_PERIOD));
    finish_test("speed_display", mark);

    mark = fails;
    wait_samples(10);
    assert (n_accepts == n_samples)
    else report_mismatch($sformatf("%0d reads accepted, %0d samples", n_accepts, n_samples));
    finish_test("flash_protocol", mark);

    $display("tests run %0d, tests failed %0d, checks failed %0d, samples %0d",
             tests_run, tests_failed, fails, n_samples);
    if (fails == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // Whole sequence plus margin
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK_50M);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

// File: ipod_player.f
design/ipod_pkg.sv
design/sample_tick_gen.sv
design/speed_control.sv
design/playback_ctrl.sv
design/flash_sample_reader.sv
design/hex_display.sv
design/ipod_top.sv
verif/tb_flash_model.sv
verif/tb_ipod_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the iPod player testbench with Verilator, run it, and judge the output

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    -f ipod_player.f --top-module tb_ipod_top \
    -Mdir obj_dir -o tb_ipod_top; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/tb_ipod_top)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
